// ==== sim.f ====
+incdir+source
source/mul_pkg.sv
source/compressor_4to2.sv
source/compressor_row.sv
source/partial_product_gen.sv
source/compressor_tree.sv
source/mul_unit_top.sv
verif/mul_unit_checker.sv
verif/mul_unit_tb.sv

// ==== verif/mul_unit_tb.sv ====
`default_nettype none

`include "mul_consts.svh"

module mul_unit_tb
    import mul_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TABLE      = 14;
    localparam int NUM_RANDOM     = 200;
    localparam int TIMEOUT_CYCLES = (NUM_TABLE + NUM_RANDOM + 20) * 4;

    typedef struct packed {
        mul_req_t          req;
        logic [63:0]       product;
    } vector_t;

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      valid_i;
    mul_req_t  req_i;
    logic      valid_o;
    mul_resp_t resp_o;

    mul_resp_t exp_q[$];
    mul_resp_t popped;
    int        cycle_count = 0;
    integer    seed = 32'h5aa3_afcd;

    vector_t vectors [NUM_TABLE] = '{
        // unsigned corners
        '{'{32'hFFFF_FFFF, 32'hFFFF_FFFF, `MUL_FUNC3_MULHU, 5'd0}, 64'hFFFF_FFFE_0000_0001},
        '{'{32'h0000_0000, 32'h1234_5678, `MUL_FUNC3_MULHU, 5'd1}, 64'h0000_0000_0000_0000},
        '{'{32'h0000_0001, 32'hFFFF_FFFF, `MUL_FUNC3_MULHU, 5'd2}, 64'h0000_0000_FFFF_FFFF},
        '{'{32'h8000_0000, 32'h0000_0002, `MUL_FUNC3_MULHU, 5'd3}, 64'h0000_0001_0000_0000},
        // signed by unsigned
        '{'{32'hFFFF_FFFF, 32'hFFFF_FFFF, `MUL_FUNC3_MULHSU, 5'd4}, 64'hFFFF_FFFF_0000_0001},
        '{'{32'h8000_0000, 32'h8000_0000, `MUL_FUNC3_MULHSU, 5'd5}, 64'hC000_0000_0000_0000},
        // MUL and MULH give the same signed product
        '{'{32'h8000_0000, 32'h8000_0000, `MUL_FUNC3_MUL, 5'd6}, 64'h4000_0000_0000_0000},
        '{'{32'h8000_0000, 32'h8000_0000, `MUL_FUNC3_MULH, 5'd7}, 64'h4000_0000_0000_0000},
        '{'{32'hFFFF_FFFF, 32'hFFFF_FFFF, `MUL_FUNC3_MUL, 5'd8}, 64'h0000_0000_0000_0001},
        '{'{32'hFFFF_FFFF, 32'hFFFF_FFFF, `MUL_FUNC3_MULH, 5'd9}, 64'h0000_0000_0000_0001},
        '{'{32'h8000_0000, 32'h0000_0001, `MUL_FUNC3_MUL, 5'd10}, 64'hFFFF_FFFF_8000_0000},
        '{'{32'h8000_0000, 32'h0000_0001, `MUL_FUNC3_MULH, 5'd11}, 64'hFFFF_FFFF_8000_0000},
        // unknown codes behave as signed
        '{'{32'hFFFF_FFFF, 32'h0000_0002, 3'b111, 5'd12}, 64'hFFFF_FFFF_FFFF_FFFE},
        '{'{32'h8000_0000, 32'hFFFF_FFFF, 3'b100, 5'd13}, 64'h0000_0000_8000_0000}
    };

    mul_unit_top DUT (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .resp_o  (resp_o)
    );

    always #4 clk_i = ~clk_i;

    // extend both operands to 64 bits and keep the low 64 bits of the product
    function automatic logic [63:0] ref_product(input mul_req_t req);
        logic [63:0] a;
        logic [63:0] b;
        a = {{32{req.op1[31]}}, req.op1};
        b = {{32{req.op2[31]}}, req.op2};
        if (req.func3 == `MUL_FUNC3_MULHSU) begin
            b = {32'h0, req.op2};
        end else if (req.func3 == `MUL_FUNC3_MULHU) begin
            a = {32'h0, req.op1};
            b = {32'h0, req.op2};
        end
        return a * b;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s mismatch, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic issue_request(input mul_req_t req, input logic [63:0] expected);
        mul_resp_t resp;
        @(posedge clk_i);
        valid_i <= 1'b1;
        req_i   <= req;
        resp.result = expected;
        resp.tag    = req.tag;
        exp_q.push_back(resp);
    endtask

    task automatic insert_idle();
        @(posedge clk_i);
        valid_i <= 1'b0;
    endtask

    ////////////////////
    // scoreboard
    ////////////////////

    always @(negedge clk_i) begin
        if (DUT.u_checker.fail_count != 0) begin
            $display("ERROR at %0t ns: a pipeline timing assertion failed", $time);
            $display("Simulation failed");
            $fatal(1, "assertion failure");
        end else if (rst_n_i && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t ns: valid_o high with no request outstanding", $time);
                $display("Simulation failed");
                $fatal(1, "unexpected response");
            end else begin
                popped = exp_q.pop_front();
                check_value(resp_o.result, popped.result, "result");
                check_value(64'(resp_o.tag), 64'(popped.tag), "tag");
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: %0d results still missing after %0d cycles",
                     exp_q.size(), cycle_count);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        mul_req_t    req;
        logic [31:0] rnd;
        rst_n_i = 1'b1;
        valid_i = 1'b0;
        req_i   = '0;
        // clean falling edge for the async reset
        #1 rst_n_i = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (int i = 0; i < NUM_TABLE; i++) begin
            issue_request(vectors[i].req, vectors[i].product);
        end
        repeat (3) insert_idle();

        // random requests with occasional idle gaps
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) begin
                insert_idle();
            end
            req.op1 = $random(seed);
            req.op2 = $random(seed);
            rnd = $random(seed);
            req.func3 = rnd[2:0];
            req.tag   = rnd[12:8];
            issue_request(req, ref_product(req));
        end
        insert_idle();

        // the last result is due three cycles after its request
        repeat (5) @(posedge clk_i);

        if (exp_q.size() == 0 && DUT.u_checker.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Run ended with %0d results missing or a failed assertion", exp_q.size());
            $display("Simulation failed");
            $fatal(1, "final check failed");
        end
    end

endmodule

`default_nettype wire

// ==== verif/mul_unit_checker.sv ====
`default_nettype none

module mul_unit_checker
    import mul_pkg::*;
(
    input wire logic      clk_i,
    input wire logic      rst_n_i,
    input wire logic      valid_i,
    input wire mul_req_t  req_i,
    input wire logic      valid_o,
    input wire mul_resp_t resp_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions so far
    int fail_count = 0;

    // fixed three stage latency
    a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o == $past(valid_i, 3))
    else begin
        fail_count++;
        $error("valid_o does not follow valid_i by three cycles");
    end

    a_tag_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> resp_o.tag == $past(req_i.tag, 3))
    else begin
        fail_count++;
        $error("response tag differs from the request tag three cycles earlier");
    end

    a_result_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> !$isunknown(resp_o))
    else begin
        fail_count++;
        $error("response holds X or Z while valid_o is high");
    end

    a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !valid_o)
    else begin
        fail_count++;
        $error("valid_o high during reset");
    end

endmodule

bind mul_unit_top mul_unit_checker u_checker (.*);

`default_nettype wire

// ==== source/mul_unit_top.sv ====
`default_nettype none

`include "mul_consts.svh"

module mul_unit_top
    import mul_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     valid_i,
    input  wire mul_req_t req_i,
    output logic          valid_o,
    output mul_resp_t     resp_o
);

    localparam int PROD_W = 2 * `MUL_DATA_LEN;

    logic                      valid_s1;
    mul_req_t                  req_s1;
    logic                      valid_s2;
    logic [`MUL_TAG_WIDTH-1:0] tag_s2;
    logic [PROD_W-1:0]         sum_s2;
    logic [PROD_W-1:0]         carry_s2;
    pp_rows_t                  pp_rows;
    logic [PROD_W-1:0]         tree_sum;
    logic [PROD_W-1:0]         tree_carry;

    ////////////////////
    // valid pipeline
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_s1 <= valid_i;
            valid_s2 <= valid_s1;
            valid_o  <= valid_s2;
        end
    end

    ////////////////////
    // datapath
    ////////////////////

    partial_product_gen u_ppgen (
        .req_i  (req_s1),
        .rows_o (pp_rows)
    );

    compressor_tree #(
        .NUM_ROWS (`MUL_DATA_LEN)
    ) u_tree (
        .rows_i  (pp_rows),
        .sum_o   (tree_sum),
        .carry_o (tree_carry)
    );

    // data regs only load on a valid stage
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            req_s1 <= req_i;
        end
        if (valid_s1) begin
            sum_s2   <= tree_sum;
            carry_s2 <= tree_carry;
            tag_s2   <= req_s1.tag;
        end
        if (valid_s2) begin
            // final carry-propagate add
            resp_o.result <= sum_s2 + carry_s2;
            resp_o.tag    <= tag_s2;
        end
    end

endmodule

`default_nettype wire

// ==== source/compressor_tree.sv ====
`default_nettype none

`include "mul_consts.svh"

module compressor_tree
    import mul_pkg::*;
#(
    parameter int NUM_ROWS = `MUL_DATA_LEN
) (
    input  wire pp_rows_t                   rows_i,
    output logic      [2*`MUL_DATA_LEN-1:0] sum_o,
    output logic      [2*`MUL_DATA_LEN-1:0] carry_o
);

    localparam int PROD_W     = 2 * `MUL_DATA_LEN;
    localparam int NUM_STAGES = $clog2(NUM_ROWS) - 1;
    localparam int NUM_NODES  = 2 * NUM_ROWS - 2;

    // rows of all stages back to back
    // stage s starts at 2*NUM_ROWS - (2*NUM_ROWS >> s)
    logic [PROD_W-1:0] node [NUM_NODES];

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_load
        assign node[r] = rows_i[r];
    end

    ////////////////////
    // reduction stages
    ////////////////////

    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
        localparam int IN_OFF  = 2*NUM_ROWS - ((2*NUM_ROWS) >> s);
        localparam int OUT_OFF = 2*NUM_ROWS - ((2*NUM_ROWS) >> (s+1));
        localparam int NUM_GRP = (NUM_ROWS >> s) / 4;

        // each group of four rows leaves a sum row and a carry row
        for (genvar g = 0; g < NUM_GRP; g++) begin : g_grp
            compressor_row u_row (
                .a_i     (node[IN_OFF + 4*g]),
                .b_i     (node[IN_OFF + 4*g + 1]),
                .c_i     (node[IN_OFF + 4*g + 2]),
                .d_i     (node[IN_OFF + 4*g + 3]),
                .sum_o   (node[OUT_OFF + 2*g]),
                .carry_o (node[OUT_OFF + 2*g + 1])
            );
        end
    end

    // last stage output, two rows
    assign sum_o   = node[NUM_NODES-2];
    assign carry_o = node[NUM_NODES-1];

endmodule

`default_nettype wire

// ==== source/partial_product_gen.sv ====
`default_nettype none

`include "mul_consts.svh"

module partial_product_gen
    import mul_pkg::*;
(
    input  wire mul_req_t req_i,
    output pp_rows_t      rows_o
);

    localparam int N = `MUL_DATA_LEN;

    mul_sign_t           sign;
    logic [N-1:0][N-1:0] mcand;
    logic                top_fix;

    ////////////////////
    // signedness decode
    ////////////////////

    always_comb begin
        case (req_i.func3)
            `MUL_FUNC3_MULHSU: begin
                sign.op1_signed = 1'b1;
                sign.op2_signed = 1'b0;
            end
            `MUL_FUNC3_MULHU: begin
                sign.op1_signed = 1'b0;
                sign.op2_signed = 1'b0;
            end
            // MUL, MULH and unknown codes
            default: begin
                sign.op1_signed = 1'b1;
                sign.op2_signed = 1'b1;
            end
        endcase
    end

    ////////////////////
    // partial products
    ////////////////////

    always_comb begin
        for (int i = 0; i < N-1; i++) begin
            mcand[i] = req_i.op1 & {N{req_i.op2[i]}};
        end

        // msb of a signed op2 weighs -2^31, so that row takes -op1
        if (sign.op2_signed) begin
            mcand[N-1] = {N{req_i.op2[N-1]}} & (~req_i.op1 + 1'b1);
        end else begin
            mcand[N-1] = {N{req_i.op2[N-1]}} & req_i.op1;
        end
    end

    // bit 63 of the last row holds for op1 = 0 and the most negative op1 too
    assign top_fix = ((sign.op1_signed & req_i.op1[N-1]) ^ (sign.op2_signed & req_i.op2[N-1]))
                   & req_i.op2[N-1] & mcand[N-1][N-1];

    always_comb begin
        for (int i = 0; i < N-1; i++) begin
            // sign-extend then shift so bits above 63 fall off
            rows_o[i] = {{N{sign.op1_signed & req_i.op2[i] & req_i.op1[N-1]}}, mcand[i]} << i;
        end
        rows_o[N-1] = {top_fix, mcand[N-1], {(N-1){1'b0}}};
    end

endmodule

`default_nettype wire

// ==== source/compressor_row.sv ====
`default_nettype none

`include "mul_consts.svh"

module compressor_row (
    input  wire logic [2*`MUL_DATA_LEN-1:0] a_i,
    input  wire logic [2*`MUL_DATA_LEN-1:0] b_i,
    input  wire logic [2*`MUL_DATA_LEN-1:0] c_i,
    input  wire logic [2*`MUL_DATA_LEN-1:0] d_i,
    output logic      [2*`MUL_DATA_LEN-1:0] sum_o,
    output logic      [2*`MUL_DATA_LEN-1:0] carry_o
);

    localparam int PROD_W = 2 * `MUL_DATA_LEN;

    logic [PROD_W-1:0] lat_carry;
    logic [PROD_W-1:0] col_carry;

    // one cell per column
    for (genvar j = 0; j < PROD_W; j++) begin : g_col
        logic cin;

        if (j == 0) begin : g_first
            assign cin = 1'b0;
        end else begin : g_next
            assign cin = lat_carry[j-1];
        end

        compressor_4to2 u_cell (
            .in1_i   (a_i[j]),
            .in2_i   (b_i[j]),
            .in3_i   (c_i[j]),
            .in4_i   (d_i[j]),
            .cin_i   (cin),
            .sum_o   (sum_o[j]),
            .carry_o (col_carry[j]),
            .cout_o  (lat_carry[j])
        );
    end

    // carry has weight two, product is mod 2^64
    assign carry_o = {col_carry[PROD_W-2:0], 1'b0};

endmodule

`default_nettype wire

// ==== source/compressor_4to2.sv ====
`default_nettype none

module compressor_4to2 (
    input  wire logic in1_i,
    input  wire logic in2_i,
    input  wire logic in3_i,
    input  wire logic in4_i,
    input  wire logic cin_i,
    output logic      sum_o,
    output logic      carry_o,
    output logic      cout_o
);

    logic fa1_sum;

    // first full adder, independent of cin so no ripple along the row
    assign fa1_sum = in1_i ^ in2_i ^ in3_i;
    assign cout_o  = (in1_i & in2_i) | (in1_i & in3_i) | (in2_i & in3_i);

    // second full adder folds in in4 and the lateral carry
    assign sum_o   = fa1_sum ^ in4_i ^ cin_i;
    assign carry_o = (fa1_sum & in4_i) | (fa1_sum & cin_i) | (in4_i & cin_i);

endmodule

`default_nettype wire

// ==== source/mul_pkg.sv ====
`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

    // request from the issue stage
    typedef struct packed {
        logic [`MUL_DATA_LEN-1:0]    op1;
        logic [`MUL_DATA_LEN-1:0]    op2;
        logic [`MUL_FUNC3_WIDTH-1:0] func3;
        logic [`MUL_TAG_WIDTH-1:0]   tag;
    } mul_req_t;

    // full product back to the rob
    typedef struct packed {
        logic [2*`MUL_DATA_LEN-1:0] result;
        logic [`MUL_TAG_WIDTH-1:0]  tag;
    } mul_resp_t;

    typedef struct packed {
        logic op1_signed;
        logic op2_signed;
    } mul_sign_t;

    // one product-width row per multiplier bit
    typedef logic [`MUL_DATA_LEN-1:0][2*`MUL_DATA_LEN-1:0] pp_rows_t;

endpackage

`default_nettype wire

// ==== source/mul_consts.svh ====
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// operand and field widths
`define MUL_DATA_LEN    32
`define MUL_FUNC3_WIDTH 3
`define MUL_TAG_WIDTH   5

// funct3 codes of the M extension multiplies
`define MUL_FUNC3_MUL    3'b000
`define MUL_FUNC3_MULH   3'b001
`define MUL_FUNC3_MULHSU 3'b010
`define MUL_FUNC3_MULHU  3'b011

`endif
